// ==== common/blk_pkg.sv ====
/*
 * Block memory types for the real-time feedback snapshot
 * Quadlet words, block addresses, read request and read response
 */

package blk_pkg;

   // ----------------------------------------------------------------------
   // Basic words
   // ----------------------------------------------------------------------
   typedef logic [31:0] quadlet_t;   // One 32-bit word
   typedef logic [4:0]  blk_addr_t;  // Quadlet address 0..31

   // ----------------------------------------------------------------------
   // Block layout
   // ----------------------------------------------------------------------
   // Word 0 is the timestamp, words 1..3 the globals. Field f of
   // channel c lands at BLK_CHAN_BASE - 1 + f*NUM_CHAN + c
   localparam int BLK_WORDS       = 32;  // Full block, 4 channels x 7 fields + 4
   localparam int BLK_TS_ADDR     = 0;   // Timestamp word
   localparam int BLK_GLOBAL_BASE = 1;   // Status, digio, temp
   localparam int BLK_CHAN_BASE   = 4;   // First per-channel word

   // ----------------------------------------------------------------------
   // Read port
   // ----------------------------------------------------------------------
   typedef struct packed {
      blk_addr_t addr;   // Requested quadlet
   } rd_req_t;

   // Address echoed back so a response can be matched to its request
   typedef struct packed {
      blk_addr_t addr;
      quadlet_t  data;
   } rd_rsp_t;

endpackage

// ==== common/fb_pkg.sv ====
/*
 * Feedback types for the four-axis controller snapshot
 * Per-channel and global quadlets, channel select and bank write
 */

package fb_pkg;

   import blk_pkg::*;

   localparam int NUM_FB_FIELDS = 7;  // Quadlets per channel

   // ----------------------------------------------------------------------
   // Per-channel feedback
   // ----------------------------------------------------------------------
   // Field order here is the field order in the block memory
   typedef struct packed {
      quadlet_t adc_in;        // Motor current and pot
      quadlet_t enc_pos;       // Quadrature position
      quadlet_t enc_period;    // Velocity as period
      quadlet_t enc_qtr1;      // Quarter period, last cycle
      quadlet_t enc_qtr5;      // Quarter period, five cycles back
      quadlet_t enc_run;       // Running counter
      quadlet_t motor_status;  // Amp and motor flags
   } chan_fb_t;

   // ----------------------------------------------------------------------
   // Board-wide feedback
   // ----------------------------------------------------------------------
   typedef struct packed {
      quadlet_t reg_status;  // Board status
      quadlet_t reg_digio;   // Digital I/O
      quadlet_t reg_temp;    // Temperature sensors
   } global_fb_t;

   // 1-based channel number, NUM_CHAN+1 means the sampler is finishing
   typedef logic [2:0] chan_idx_t;

   // Bank write, chan is 0-based here
   typedef struct packed {
      logic [1:0] chan;
      chan_fb_t   data;
   } fb_wr_t;

endpackage

// ==== logic/block_reader.sv ====
/*
 * Snapshot block reader
 * Answers quadlet read strobes one cycle later and holds a read
 * arriving mid-sample until the snapshot is complete
 */

module block_reader
   import blk_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      rd_req_valid,   // Read strobe
   input  rd_req_t   rd_req,         // Requested address
   input  logic      busy,           // Sampler is writing the block
   output blk_addr_t mem_addr,       // Address to the snapshot memory
   input  quadlet_t  mem_data,       // Word at mem_addr
   output logic      rd_rsp_valid,   // One-cycle response strobe
   output rd_rsp_t   rd_rsp          // Address and data
);

   logic      pending;               // A read waits for busy to drop
   blk_addr_t pend_addr;             // Address of the waiting read
   logic      issue;                 // Respond at this edge

   // ----------------------------------------------------------------------
   // Request selection
   // ----------------------------------------------------------------------
   // A fresh strobe always wins over a held one
   assign mem_addr = rd_req_valid ? rd_req.addr : pend_addr;

   // Never answer while the block is half written
   assign issue = (rd_req_valid || pending) && !busy;

   // ----------------------------------------------------------------------
   // Control
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         pending      <= 1'b0;
         rd_rsp_valid <= 1'b0;
      end else begin
         rd_rsp_valid <= issue;           // Single-cycle strobe
         if (issue) begin
            pending <= 1'b0;
         end else if (rd_req_valid) begin
            pending <= 1'b1;              // Arrived while busy
         end
      end
   end

   // ----------------------------------------------------------------------
   // Payload
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rd_req_valid) begin
         pend_addr <= rd_req.addr;        // Replaces any held read
      end
      if (issue) begin
         rd_rsp.addr <= mem_addr;         // Echo for matching
         rd_rsp.data <= mem_data;
      end
   end

endmodule

// ==== logic/chan_feedback_bank.sv ====
/*
 * Per-channel feedback register bank
 * Latches each channel's feedback on a write strobe and presents the
 * channel the sampler selects
 */

module chan_feedback_bank
   import fb_pkg::*;
#(
   parameter int NUM_CHAN = 4        // 1..4 channels
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      fb_wr_valid,    // Write strobe
   input  fb_wr_t    fb_wr,          // Channel and its feedback
   input  chan_idx_t sel_chan,       // 1-based select from sampler
   output chan_fb_t  sel_fb          // Selected channel, zero if out of range
);

   chan_fb_t   fb_reg [NUM_CHAN];    // One register set per channel
   logic [1:0] sel_idx;              // 0-based form of sel_chan
   logic       sel_ok;               // sel_chan within 1..NUM_CHAN
   logic       wr_ok;                // Write targets an existing channel

   // ----------------------------------------------------------------------
   // Write side
   // ----------------------------------------------------------------------
   assign wr_ok = fb_wr_valid && (int'(fb_wr.chan) < NUM_CHAN);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            fb_reg[c] <= '0;
         end
      end else if (wr_ok) begin
         fb_reg[fb_wr.chan] <= fb_wr.data;  // Visible from next cycle
      end
   end

   // ----------------------------------------------------------------------
   // Select side
   // ----------------------------------------------------------------------
   assign sel_ok  = (sel_chan != '0) && (int'(sel_chan) <= NUM_CHAN);
   assign sel_idx = 2'(sel_chan - 3'd1);  // Channel 1 lives at index 0

   always_comb begin
      sel_fb = '0;                   // Idle and finishing selects read zero
      if (sel_ok) begin
         sel_fb = fb_reg[sel_idx];
      end
   end

endmodule

// ==== logic/rt_feedback_top.sv ====
/*
 * Real-time feedback snapshot top level
 * Feedback bank, sampler and block reader
 */

module rt_feedback_top
   import fb_pkg::*;
   import blk_pkg::*;
#(
   parameter int NUM_CHAN = 4        // 1..4 channels
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       fb_wr_valid,   // Feedback write strobe
   input  fb_wr_t     fb_wr,
   input  global_fb_t global_fb,     // Board-wide feedback level
   input  logic       sample_req,    // Snapshot strobe
   output logic       busy,
   output quadlet_t   timestamp,
   input  logic       rd_req_valid,  // Quadlet read strobe
   input  rd_req_t    rd_req,
   output logic       rd_rsp_valid,
   output rd_rsp_t    rd_rsp
);

   chan_idx_t sel_chan;              // Sampler to bank
   chan_fb_t  sel_fb;                // Bank to sampler
   blk_addr_t mem_addr;              // Reader to sampler memory
   quadlet_t  mem_data;

   chan_feedback_bank #(
      .NUM_CHAN (NUM_CHAN)
   ) chan_feedback_bank_inst (
      .clk         (clk),
      .rst         (rst),
      .fb_wr_valid (fb_wr_valid),
      .fb_wr       (fb_wr),
      .sel_chan    (sel_chan),
      .sel_fb      (sel_fb)
   );

   sample_data #(
      .NUM_CHAN (NUM_CHAN)
   ) sample_data_inst (
      .clk        (clk),
      .rst        (rst),
      .sample_req (sample_req),
      .busy       (busy),
      .global_fb  (global_fb),
      .sel_chan   (sel_chan),
      .sel_fb     (sel_fb),
      .mem_addr   (mem_addr),
      .mem_data   (mem_data),
      .timestamp  (timestamp)
   );

   block_reader block_reader_inst (
      .clk          (clk),
      .rst          (rst),
      .rd_req_valid (rd_req_valid),
      .rd_req       (rd_req),
      .busy         (busy),
      .mem_addr     (mem_addr),
      .mem_data     (mem_data),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp       (rd_rsp)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the feedback snapshot testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
   echo "Could not create $BUILD_DIR"
   exit 1
fi

verilator --binary --timing --top-module rt_feedback_tb -f sources.f \
   -Mdir "$BUILD_DIR/obj_dir" -o rt_feedback_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"$BUILD_DIR/obj_dir/rt_feedback_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0

// ==== sampler/sample_data.sv ====
/*
 * Real-time feedback sampler
 * Walks the channels one per clock on a sample strobe, copying timestamp,
 * globals and channel feedback into a 32-quadlet snapshot memory
 */

module sample_data
   import fb_pkg::*;
   import blk_pkg::*;
#(
   parameter int NUM_CHAN = 4          // 1..4 channels
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       sample_req,      // Single-cycle sample strobe
   output logic       busy,            // High while the snapshot is written
   input  global_fb_t global_fb,       // Board-wide feedback
   output chan_idx_t  sel_chan,        // 1-based channel to the bank
   input  chan_fb_t   sel_fb,          // Feedback of sel_chan
   input  blk_addr_t  mem_addr,        // Read address from the reader
   output quadlet_t   mem_data,        // Snapshot word at mem_addr
   output quadlet_t   timestamp        // Free-running cycle count
);

   localparam chan_idx_t FIRST_CHAN = 3'd1;
   localparam chan_idx_t DONE_CHAN  = chan_idx_t'(NUM_CHAN + 1);  // Finishing step

   typedef enum logic {
      ST_IDLE,
      ST_SAMPLE
   } state_t;

   state_t    state;
   quadlet_t  snap_mem [BLK_WORDS];       // Snapshot block
   quadlet_t  fld_data [NUM_FB_FIELDS];   // Selected channel, by field number
   blk_addr_t fld_addr [NUM_FB_FIELDS];   // Where each field goes
   logic      first_step;                 // First busy cycle
   logic      chan_step;                  // A channel is stored this cycle

   assign busy       = (state == ST_SAMPLE);
   assign first_step = busy && (sel_chan == FIRST_CHAN);
   assign chan_step  = busy && (sel_chan != DONE_CHAN);

   // ----------------------------------------------------------------------
   // Sequencer and timestamp
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         sel_chan  <= '0;
         timestamp <= '0;
      end else begin
         // Cleared as the old count is captured into word 0
         timestamp <= first_step ? '0 : timestamp + 32'd1;
         case (state)
            ST_IDLE: begin
               if (sample_req) begin       // Requests while busy are dropped
                  sel_chan <= FIRST_CHAN;
                  state    <= ST_SAMPLE;
               end
            end
            ST_SAMPLE: begin
               if (sel_chan == DONE_CHAN) begin
                  sel_chan <= '0;          // Bank select back to none
                  state    <= ST_IDLE;
               end else begin
                  sel_chan <= sel_chan + 3'd1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Field scatter
   // ----------------------------------------------------------------------
   assign fld_data[0] = sel_fb.adc_in;
   assign fld_data[1] = sel_fb.enc_pos;
   assign fld_data[2] = sel_fb.enc_period;
   assign fld_data[3] = sel_fb.enc_qtr1;
   assign fld_data[4] = sel_fb.enc_qtr5;
   assign fld_data[5] = sel_fb.enc_run;
   assign fld_data[6] = sel_fb.motor_status;

   // Fields are grouped by kind, channels interleaved within a group
   always_comb begin
      for (int f = 0; f < NUM_FB_FIELDS; f++) begin
         fld_addr[f] = blk_addr_t'(BLK_CHAN_BASE - 1 + f * NUM_CHAN + int'(sel_chan));
      end
   end

   // ----------------------------------------------------------------------
   // Snapshot memory
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (first_step) begin
         snap_mem[BLK_TS_ADDR]         <= timestamp;  // Cycles since last clear
         snap_mem[BLK_GLOBAL_BASE]     <= global_fb.reg_status;
         snap_mem[BLK_GLOBAL_BASE + 1] <= global_fb.reg_digio;
         snap_mem[BLK_GLOBAL_BASE + 2] <= global_fb.reg_temp;
      end
      if (chan_step) begin
         for (int f = 0; f < NUM_FB_FIELDS; f++) begin
            snap_mem[fld_addr[f]] <= fld_data[f];
         end
      end
   end

   assign mem_data = snap_mem[mem_addr];  // Asynchronous read port

endmodule

// ==== sources.f ====
common/blk_pkg.sv
common/fb_pkg.sv
logic/chan_feedback_bank.sv
sampler/sample_data.sv
logic/block_reader.sv
logic/rt_feedback_top.sv
verif/rt_feedback_tb.sv

// ==== verif/rt_feedback_tb.sv ====
/*
 * Testbench for the real-time feedback snapshot
 * Random bank writes, samples and block reads checked against a model
 */

module rt_feedback_tb
   import fb_pkg::*;
   import blk_pkg::*;
();

   localparam int NUM_CHAN    = 4;
   localparam int BUSY_CYCLES = NUM_CHAN + 1;
   localparam int NUM_ROUNDS  = 25;               // Five directed tests plus twenty random rounds
   localparam int WDOG_CYCLES = 200 * NUM_ROUNDS;

   logic       clk;
   logic       rst;
   logic       fb_wr_valid;
   fb_wr_t     fb_wr;
   global_fb_t global_fb;
   logic       sample_req;
   logic       busy;
   quadlet_t   timestamp;
   logic       rd_req_valid;
   rd_req_t    rd_req;
   logic       rd_rsp_valid;
   rd_rsp_t    rd_rsp;

   int         seed      = 32'h5851;
   int         cyc       = 0;                     // Rising edges since time 0
   int         clear_cyc = 0;                     // Edge after which timestamp was 0
   int         err_cnt   = 0;
   int         chk_cnt   = 0;
   int         test_err  = 0;                     // err_cnt at start of current test

   chan_fb_t   bank_model [NUM_CHAN];             // Mirror of the bank registers
   global_fb_t glob_model;
   quadlet_t   snap_model [BLK_WORDS];            // Expected snapshot block

   rt_feedback_top #(
      .NUM_CHAN (NUM_CHAN)
   ) rt_feedback_top_inst (
      .clk          (clk),
      .rst          (rst),
      .fb_wr_valid  (fb_wr_valid),
      .fb_wr        (fb_wr),
      .global_fb    (global_fb),
      .sample_req   (sample_req),
      .busy         (busy),
      .timestamp    (timestamp),
      .rd_req_valid (rd_req_valid),
      .rd_req       (rd_req),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp       (rd_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   initial begin
      repeat (WDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------
   task automatic check_quadlet(input string name, input quadlet_t got, input quadlet_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic check_rsp(input string name, input rd_rsp_t got, input rd_rsp_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR %s got addr %h data %h expected addr %h data %h at cycle %0d",
                  name, got.addr, got.data, exp.addr, exp.data, cyc);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic report_test(input string name);
      if (err_cnt == test_err) begin
         $display("%-26s ok, 0 errors", name);
      end else begin
         $display("%-26s failed, %0d errors", name, err_cnt - test_err);
      end
      test_err = err_cnt;
   endtask

   // ----------------------------------------------------------------------
   // Model
   // ----------------------------------------------------------------------
   function automatic quadlet_t field_of(input chan_fb_t fb, input int f);
      case (f)
         0: return fb.adc_in;
         1: return fb.enc_pos;
         2: return fb.enc_period;
         3: return fb.enc_qtr1;
         4: return fb.enc_qtr5;
         5: return fb.enc_run;
         default: return fb.motor_status;
      endcase
   endfunction

   function automatic chan_fb_t rand_fb();
      chan_fb_t fb;
      for (int f = 0; f < NUM_FB_FIELDS; f++) begin
         fb[f*32 +: 32] = $random(seed);
      end
      return fb;
   endfunction

   // Word 0 timestamp, then globals, then fields grouped by kind
   task automatic build_snapshot(input quadlet_t ts);
      snap_model[0]                                = ts;
      snap_model[blk_addr_t'(BLK_GLOBAL_BASE)]     = glob_model.reg_status;
      snap_model[blk_addr_t'(BLK_GLOBAL_BASE + 1)] = glob_model.reg_digio;
      snap_model[blk_addr_t'(BLK_GLOBAL_BASE + 2)] = glob_model.reg_temp;
      for (int c = 1; c <= NUM_CHAN; c++) begin
         for (int f = 0; f < NUM_FB_FIELDS; f++) begin
            snap_model[blk_addr_t'(BLK_CHAN_BASE - 1 + f * NUM_CHAN + c)] =
               field_of(bank_model[2'(c - 1)], f);
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Drivers
   // ----------------------------------------------------------------------
   task automatic write_chan(input int c, input chan_fb_t d);
      fb_wr_valid = 1'b1;
      fb_wr.chan  = 2'(c);
      fb_wr.data  = d;
      @(posedge clk);
      #1;
      fb_wr_valid      = 1'b0;
      bank_model[2'(c)] = d;                      // Visible to the sampler from now on
   endtask

   task automatic set_globals();
      global_fb.reg_status = $random(seed);
      global_fb.reg_digio  = $random(seed);
      global_fb.reg_temp   = $random(seed);
      glob_model           = global_fb;
   endtask

   task automatic read_word(input blk_addr_t addr);
      rd_rsp_t exp;
      exp.addr     = addr;
      exp.data     = snap_model[addr];
      rd_req_valid = 1'b1;
      rd_req.addr  = addr;
      @(posedge clk);
      #1;
      rd_req_valid = 1'b0;
      check_flag("rd_rsp_valid", rd_rsp_valid, 1'b1);  // Idle read answers after one cycle
      check_rsp("rd_rsp", rd_rsp, exp);
   endtask

   // dup_at and rd_at pick a busy cycle for an extra strobe or -1 for none
   task automatic run_sample(input int dup_at, input int rd_at, input blk_addr_t rd_addr);
      rd_rsp_t exp;
      build_snapshot(quadlet_t'(cyc + 1 - clear_cyc));  // Count held in first busy cycle
      check_flag("busy", busy, 1'b0);
      sample_req = 1'b1;
      @(posedge clk);
      #1;
      sample_req = 1'b0;
      clear_cyc  = cyc + 1;                       // Cleared at end of this cycle
      for (int i = 0; i < BUSY_CYCLES; i++) begin
         check_flag("busy", busy, 1'b1);
         check_flag("rd_rsp_valid", rd_rsp_valid, 1'b0);
         sample_req   = (i == dup_at);
         rd_req_valid = (i == rd_at);
         rd_req.addr  = rd_addr;
         @(posedge clk);
         #1;
      end
      sample_req   = 1'b0;
      rd_req_valid = 1'b0;
      check_flag("busy", busy, 1'b0);
      check_flag("rd_rsp_valid", rd_rsp_valid, 1'b0);  // Held read still waiting
      @(posedge clk);
      #1;
      check_flag("busy", busy, 1'b0);             // Dropped request must not start late
      if (rd_at >= 0) begin
         exp.addr = rd_addr;
         exp.data = snap_model[rd_addr];
         check_flag("rd_rsp_valid", rd_rsp_valid, 1'b1);
         check_rsp("rd_rsp", rd_rsp, exp);
      end
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      int gap;
      int start_cyc;
      int n_wr;
      int idle;
      int wc;
      int fld;
      rst          = 1'b1;
      fb_wr_valid  = 1'b0;
      fb_wr        = '0;
      global_fb    = '0;
      sample_req   = 1'b0;
      rd_req_valid = 1'b0;
      rd_req       = '0;
      glob_model   = '0;
      for (int c = 0; c < NUM_CHAN; c++) begin
         bank_model[2'(c)] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst       = 1'b0;
      clear_cyc = cyc;

      check_flag("busy", busy, 1'b0);
      check_flag("rd_rsp_valid", rd_rsp_valid, 1'b0);
      for (int i = 0; i < 10; i++) begin
         check_quadlet("timestamp", timestamp, quadlet_t'(cyc - clear_cyc));
         @(posedge clk);
         #1;
      end
      report_test("reset and timestamp");

      for (int c = 0; c < NUM_CHAN; c++) begin
         write_chan(c, rand_fb());
      end
      set_globals();
      run_sample(-1, -1, '0);
      for (int a = 0; a < BLK_WORDS; a++) begin
         read_word(blk_addr_t'(a));
      end
      report_test("full snapshot readback");

      gap       = 10 + int'({$random(seed)} % 50);
      start_cyc = cyc;
      run_sample(-1, -1, '0);
      while (cyc < start_cyc + gap) begin
         @(posedge clk);
         #1;
      end
      run_sample(-1, -1, '0);
      read_word(blk_addr_t'(BLK_TS_ADDR));        // Cycles since the first clear
      report_test($sformatf("sample gap of %0d", gap));

      write_chan(0, rand_fb());
      set_globals();
      run_sample(2, -1, '0);
      check_quadlet("timestamp", timestamp, quadlet_t'(cyc - clear_cyc));
      read_word(blk_addr_t'(BLK_TS_ADDR));
      read_word(blk_addr_t'($random(seed)));
      report_test("request during busy");

      wc  = int'({$random(seed)} % NUM_CHAN);
      fld = int'({$random(seed)} % NUM_FB_FIELDS);
      write_chan(wc, rand_fb());
      set_globals();
      // Read lands before any word is rewritten and targets a field this sample changes
      run_sample(-1, 0, blk_addr_t'(BLK_CHAN_BASE - 1 + fld * NUM_CHAN + wc + 1));
      report_test("read during busy");

      for (int r = 0; r < 20; r++) begin
         n_wr = 1 + int'({$random(seed)} % 4);
         for (int w = 0; w < n_wr; w++) begin
            write_chan(int'({$random(seed)} % NUM_CHAN), rand_fb());
         end
         set_globals();
         idle = int'({$random(seed)} % 8);
         repeat (idle) begin
            @(posedge clk);
            #1;
         end
         if ({$random(seed)} % 4 == 0) begin    // Some rounds read mid-sample
            run_sample(-1, int'({$random(seed)} % BUSY_CYCLES), blk_addr_t'($random(seed)));
         end else begin
            run_sample(-1, -1, '0);
         end
         for (int k = 0; k < 3; k++) begin
            read_word(blk_addr_t'($random(seed)));
         end
      end
      report_test("random rounds");

      $display("Checks run %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
